// File: controlUnit.f
logic/cpuControlPkg.sv
logic/instrDecoder.sv
logic/conditionCheck.sv
logic/controlSequencer.sv
logic/controlWordRom.sv
logic/controlUnit.sv
test/controlUnit_checker.sv
test/controlUnitTb.sv

// File: Makefile
TOP = controlUnitTb

all: run

run:
	verilator --binary --timing --assert -f controlUnit.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing --assert -f controlUnit.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: test/controlUnitTb.sv
`timescale 1ns/1ns

module controlUnitTb
	import cpuControlPkg::*;
;

	localparam int INSTR_COUNT = 300;
	localparam int CYCLE_LIMIT = INSTR_COUNT * 10 + 200;

	logic     CLK = 1'b0;
	logic     CLR;
	irT       ir;
	flagsT    flags;
	logic     moc;
	logic     rfLd, irLd, marLd, mdrLd, frLd, rw, mov, md, mh, e, mbSel, miSel;
	sel2T     maSel, mfSel, mjSel;
	sel3T     mcSel;
	shiftT    shiftType;
	shiftSelT shiftSel;
	aluOpT    aluOp;

	stateT       modelState = stIdle;
	logic [31:0] seed = 32'd15;
	logic [1:0]  waitLeft = 2'd0;
	int          cycles = 0;
	int          instrDone = 0;
	int          errorCount = 0;
	int          timeoutCount = 0;

	controlUnit dut0 (.*);

	always #10 CLK = ~CLK;

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// ARM style evaluation where odd codes invert the even code below them
	function automatic logic condHolds(condT c, flagsT f);
		logic base;
		case (c[3:1])
			3'b000: base = f[2];
			3'b001: base = f[1];
			3'b010: base = f[3];
			3'b011: base = f[0];
			3'b100: base = f[1] && !f[2];
			3'b101: base = (f[3] == f[0]);
			3'b110: base = !f[2] && (f[3] == f[0]);
			default: base = 1'b1;
		endcase
		if (c == 4'b1111)
			return 1'b0;
		return c[0] ? !base : base;
	endfunction

	function automatic stateT modelNext(stateT s, irT instr, flagsT f, logic memDone);
		opClassT cls;
		cls = instr[IR_CLASS_LSB +: 3];
		case (s)
			stIdle: return stFetchAddr;
			stFetchAddr: return stFetchInc;
			stFetchInc: return stFetchWait;
			stFetchWait: return memDone ? stDecode : stFetchWait;
			stDecode:
			begin
				if (!condHolds(instr[IR_COND_LSB +: 4], f))
					return stFetchAddr;
				if (cls == OPC_DP_SHIFT)
					return stDpShift;
				if (cls == OPC_DP_IMM)
					return stDpImm;
				if (cls == OPC_BRANCH)
					return instr[IR_LINK_BIT] ? stBrLink : stBrTarget;
				return stFetchAddr;
			end
			stDpShift: return stDpFlags;
			stBrLink: return stBrTarget;
			stBrTarget: return stBrWrite;
			default: return stFetchAddr;
		endcase
	endfunction

	task automatic compareValue(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// expected control word per model state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic checkOutputs();
		logic eRf, eIr, eMar, eMdr, eFr, eRw, eMov, eMd, eMh, eE, eMb, eMi;
		logic [1:0] eMa, eMf, eMj;
		logic [2:0] eMc, eShT;
		logic [5:0] eShS;
		logic [4:0] eAlu;
		{eRf, eIr, eMar, eMdr, eFr, eRw, eMov, eMd, eMh, eE, eMb, eMi} = '0;
		{eMa, eMf, eMj, eMc, eShT, eShS, eAlu} = '0;
		case (modelState)
			stFetchAddr:
			begin
				{eMar, eMd} = '1;
				eMa = 2'b10;
				eAlu = ALU_PASS;
			end
			stFetchInc:
			begin
				{eRf, eRw, eMov, eMd} = '1;
				eMa = 2'b10;
				eMc = 3'b001;
				eAlu = ALU_INC;
			end
			stFetchWait:
				{eIr, eRw, eMov} = '1;
			stDpShift:
			begin
				{eRf, eMb, eMd, eE} = '1;
				eMc = 3'b100;
				eShT = 3'b001;
				eAlu = ALU_FROM_IR;
			end
			stDpFlags:
			begin
				{eRf, eFr} = '1;
				eMj = 2'b01;
			end
			stDpImm:
				{eRf, eFr, eMb, eMh, eMi} = '1;
			stBrLink:
			begin
				{eRf, eMd} = '1;
				eMa = 2'b11;
				eMc = 3'b100;
				eMj = 2'b01;
				eShS = 6'b000100;
				eAlu = ALU_ADD;
			end
			stBrTarget:
			begin
				{eRf, eFr, eMb, eMd, eE} = '1;
				eMc = 3'b100;
				eMf = 2'b11;
				eMj = 2'b11;
				eShT = 3'b100;
				eAlu = ALU_FROM_IR;
			end
			stBrWrite:
			begin
				{eRf, eMd} = '1;
				eMa = 2'b10;
				eMc = 3'b011;
				eMj = 2'b01;
				eShS = 6'b000100;
				eAlu = ALU_ADD;
			end
			default: ;
		endcase
		compareValue("rfLd", 32'(eRf), 32'(rfLd));
		compareValue("irLd", 32'(eIr), 32'(irLd));
		compareValue("marLd", 32'(eMar), 32'(marLd));
		compareValue("mdrLd", 32'(eMdr), 32'(mdrLd));
		compareValue("frLd", 32'(eFr), 32'(frLd));
		compareValue("rw", 32'(eRw), 32'(rw));
		compareValue("mov", 32'(eMov), 32'(mov));
		compareValue("md", 32'(eMd), 32'(md));
		compareValue("mh", 32'(eMh), 32'(mh));
		compareValue("e", 32'(eE), 32'(e));
		compareValue("mbSel", 32'(eMb), 32'(mbSel));
		compareValue("miSel", 32'(eMi), 32'(miSel));
		compareValue("maSel", 32'(eMa), 32'(maSel));
		compareValue("mfSel", 32'(eMf), 32'(mfSel));
		compareValue("mjSel", 32'(eMj), 32'(mjSel));
		compareValue("mcSel", 32'(eMc), 32'(mcSel));
		compareValue("shiftType", 32'(eShT), 32'(shiftType));
		compareValue("shiftSel", 32'(eShS), 32'(shiftSel));
		compareValue("aluOp", 32'(eAlu), 32'(aluOp));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// model step and stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge CLK)
	begin : modelStep
		stateT       nextSt;
		logic [31:0] r;
		opClassT     cls;
		cycles <= cycles + 1;
		if (!CLR)
			nextSt = stIdle;
		else
			nextSt = modelNext(modelState, ir, flags, moc);
		if (modelState == stDecode)
			instrDone <= instrDone + 1;
		modelState <= nextSt;
		// a new instruction and new flags are presented at the start of each fetch
		if (nextSt == stFetchAddr)
		begin
			r = nextRandom();
			case (r[31:16] % 16'd5)
				16'd0: cls = OPC_DP_SHIFT;
				16'd1: cls = OPC_DP_IMM;
				16'd2: cls = OPC_BRANCH;
				16'd3: cls = 3'b010;
				default: cls = 3'b110;
			endcase
			flags <= r[15:12];
			r = nextRandom();
			ir <= {r[31:28], cls, r[24:21], r[17], r[19:0]};
		end
		if (nextSt == stFetchInc)
		begin
			r = nextRandom();
			waitLeft = r[21:20];
		end
		if (nextSt == stFetchWait)
		begin
			moc <= (waitLeft == 2'd0);
			if (waitLeft != 2'd0)
				waitLeft = waitLeft - 2'd1;
		end
		else
			moc <= 1'b0;
	end

	always @(negedge CLK)
		checkOutputs();

	initial
	begin
		CLR = 1'b0;
		ir = '0;
		flags = '0;
		moc = 1'b0;
		repeat (4) @(posedge CLK);
		CLR <= 1'b1;
		while (instrDone < INSTR_COUNT && cycles < CYCLE_LIMIT)
			@(posedge CLK);
		if (instrDone < INSTR_COUNT)
		begin
			timeoutCount++;
			$display("the run timed out after %0d cycles with %0d instructions done",
				cycles, instrDone);
		end
		// the check at the falling edge in between has finished by the next rising edge
		@(posedge CLK);
		$display("mismatches %0d, timeouts %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: test/controlUnit_checker.sv
`timescale 1ns/1ns

module controlUnitChecker
(
	input logic CLK,
	input logic CLR,
	input logic moc,
	input logic irLd,
	input logic rfLd,
	input logic marLd,
	input logic rw
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fetch protocol properties
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// the instruction register and the register file never load together
	irNotWithRf: assert property (@(posedge CLK) disable iff (!CLR) !(irLd && rfLd))
		else $error("irLd and rfLd are high in the same cycle");

	// a memory that has not answered keeps the wait state alive
	waitHolds: assert property (@(posedge CLK) disable iff (!CLR) (irLd && !moc) |=> irLd)
		else $error("irLd dropped before moc was seen high");

	marThenRead: assert property (@(posedge CLK) disable iff (!CLR) marLd |=> rw)
		else $error("marLd was not followed by rw");

endmodule

bind controlUnit controlUnitChecker checker0 (
	.CLK   (CLK),
	.CLR   (CLR),
	.moc   (moc),
	.irLd  (irLd),
	.rfLd  (rfLd),
	.marLd (marLd),
	.rw    (rw)
);

// File: logic/controlUnit.sv
`timescale 1ns/1ns

module controlUnit
	import cpuControlPkg::*;
(
	input  logic     CLK,
	input  logic     CLR,
	input  irT       ir,
	input  flagsT    flags,
	input  logic     moc,
	output logic     rfLd,
	output logic     irLd,
	output logic     marLd,
	output logic     mdrLd,
	output logic     frLd,
	output logic     rw,
	output logic     mov,
	output logic     md,
	output logic     mh,
	output logic     e,
	output logic     mbSel,
	output logic     miSel,
	output sel2T     maSel,
	output sel2T     mfSel,
	output sel2T     mjSel,
	output sel3T     mcSel,
	output shiftT    shiftType,
	output shiftSelT shiftSel,
	output aluOpT    aluOp
);

	stateT execTarget;
	stateT state;
	logic  condPass;

	instrDecoder decoder0 (
		.ir         (ir),
		.execTarget (execTarget)
	);

	conditionCheck condCheck0 (
		.ir       (ir),
		.flags    (flags),
		.condPass (condPass)
	);

	controlSequencer sequencer0 (
		.CLK        (CLK),
		.CLR        (CLR),
		.moc        (moc),
		.condPass   (condPass),
		.execTarget (execTarget),
		.state      (state)
	);

	// the control word follows the state with no register stage
	controlWordRom wordRom0 (
		.state     (state),
		.rfLd      (rfLd),
		.irLd      (irLd),
		.marLd     (marLd),
		.mdrLd     (mdrLd),
		.frLd      (frLd),
		.rw        (rw),
		.mov       (mov),
		.md        (md),
		.mh        (mh),
		.e         (e),
		.mbSel     (mbSel),
		.miSel     (miSel),
		.maSel     (maSel),
		.mfSel     (mfSel),
		.mjSel     (mjSel),
		.mcSel     (mcSel),
		.shiftType (shiftType),
		.shiftSel  (shiftSel),
		.aluOp     (aluOp)
	);

endmodule

// File: logic/controlWordRom.sv
`timescale 1ns/1ns

module controlWordRom
	import cpuControlPkg::*;
(
	input  stateT    state,
	output logic     rfLd,
	output logic     irLd,
	output logic     marLd,
	output logic     mdrLd,
	output logic     frLd,
	output logic     rw,
	output logic     mov,
	output logic     md,
	output logic     mh,
	output logic     e,
	output logic     mbSel,
	output logic     miSel,
	output sel2T     maSel,
	output sel2T     mfSel,
	output sel2T     mjSel,
	output sel3T     mcSel,
	output shiftT    shiftType,
	output shiftSelT shiftSel,
	output aluOpT    aluOp
);

	always_comb
	begin
		// each state only raises its own bits over a cleared word
		{rfLd, irLd, marLd, mdrLd, frLd, rw, mov, md, mh, e} = '0;
		{mbSel, miSel, maSel, mfSel, mjSel, mcSel} = '0;
		{shiftType, shiftSel, aluOp} = '0;
		case (state)
			stFetchAddr:
			begin
				{marLd, md} = '1;
				maSel = 2'b10;
				aluOp = ALU_PASS;
			end
			stFetchInc:
			begin
				{rfLd, rw, mov, md} = '1;
				maSel = 2'b10;
				mcSel = 3'b001;
				aluOp = ALU_INC;
			end
			stFetchWait:
				{irLd, rw, mov} = '1;
			stDpShift:
			begin
				{rfLd, mbSel, md, e} = '1;
				mcSel = 3'b100;
				shiftType = 3'b001;
				aluOp = ALU_FROM_IR;
			end
			stDpFlags:
			begin
				{rfLd, frLd} = '1;
				mjSel = 2'b01;
			end
			stDpImm:
				{rfLd, frLd, mbSel, mh, miSel} = '1;
			stBrLink:
			begin
				// saves the return address before the branch target overwrites the PC
				{rfLd, md} = '1;
				maSel = 2'b11;
				mcSel = 3'b100;
				mjSel = 2'b01;
				shiftSel = 6'b000100;
				aluOp = ALU_ADD;
			end
			stBrTarget:
			begin
				{rfLd, frLd, mbSel, md, e} = '1;
				mcSel = 3'b100;
				mfSel = 2'b11;
				mjSel = 2'b11;
				shiftType = 3'b100;
				aluOp = ALU_FROM_IR;
			end
			stBrWrite:
			begin
				{rfLd, md} = '1;
				maSel = 2'b10;
				mcSel = 3'b011;
				mjSel = 2'b01;
				shiftSel = 6'b000100;
				aluOp = ALU_ADD;
			end
			// stIdle and stDecode keep the cleared word
			default: ;
		endcase
	end

endmodule

// File: logic/controlSequencer.sv
`timescale 1ns/1ns

module controlSequencer
	import cpuControlPkg::*;
(
	input  logic  CLK,
	input  logic  CLR,
	input  logic  moc,
	input  logic  condPass,
	input  stateT execTarget,
	output stateT state
);

	stateT nextState;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// state register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK or negedge CLR)
	begin
		if (!CLR)
			state <= stIdle;
		else
			state <= nextState;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		nextState = state;
		case (state)
			stIdle:
				nextState = stFetchAddr;
			stFetchAddr:
				nextState = stFetchInc;
			stFetchInc:
				nextState = stFetchWait;
			stFetchWait:
			begin
				// the memory holds us here until the read completes
				if (moc)
					nextState = stDecode;
				else
					nextState = stFetchWait;
			end
			stDecode:
			begin
				// a failed condition retires the instruction at once
				if (condPass)
					nextState = execTarget;
				else
					nextState = stFetchAddr;
			end
			stDpShift:
				nextState = stDpFlags;
			stDpFlags:
				nextState = stFetchAddr;
			stDpImm:
				nextState = stFetchAddr;
			stBrLink:
				nextState = stBrTarget;
			stBrTarget:
				nextState = stBrWrite;
			stBrWrite:
				nextState = stFetchAddr;
			default:
				nextState = stIdle;
		endcase
	end

endmodule

// File: logic/conditionCheck.sv
`timescale 1ns/1ns

module conditionCheck
	import cpuControlPkg::*;
(
	input  irT    ir,
	input  flagsT flags,
	output logic  condPass
);

	condT condCode;
	logic flagN;
	logic flagZ;
	logic flagC;
	logic flagV;

	assign condCode = ir[IR_COND_LSB +: $bits(condT)];

	// flags are packed as N Z C V from the top bit down
	assign flagN = flags[3];
	assign flagZ = flags[2];
	assign flagC = flags[1];
	assign flagV = flags[0];

	always_comb
	begin
		condPass = 1'b0;
		case (condCode)
			COND_EQ: condPass = flagZ;
			COND_NE: condPass = !flagZ;
			COND_CS: condPass = flagC;
			COND_CC: condPass = !flagC;
			COND_MI: condPass = flagN;
			COND_PL: condPass = !flagN;
			COND_VS: condPass = flagV;
			COND_VC: condPass = !flagV;
			COND_HI: condPass = flagC && !flagZ;
			COND_LS: condPass = !flagC || flagZ;
			COND_GE: condPass = (flagN == flagV);
			COND_LT: condPass = (flagN != flagV);
			COND_GT: condPass = !flagZ && (flagN == flagV);
			COND_LE: condPass = flagZ || (flagN != flagV);
			COND_AL: condPass = 1'b1;
			COND_NV: condPass = 1'b0;
		endcase
	end

endmodule

// File: logic/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder
	import cpuControlPkg::*;
(
	input  irT    ir,
	output stateT execTarget
);

	opClassT opClass;
	logic    linkBit;

	assign opClass = ir[IR_CLASS_LSB +: $bits(opClassT)];
	assign linkBit = ir[IR_LINK_BIT];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// first execute state per class
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		case (opClass)
			OPC_DP_SHIFT:
				execTarget = stDpShift;
			OPC_DP_IMM:
				execTarget = stDpImm;
			OPC_BRANCH:
			begin
				// the link copy runs before the target is formed
				if (linkBit)
					execTarget = stBrLink;
				else
					execTarget = stBrTarget;
			end
			default:
				// load/store and unused classes retire without doing anything
				execTarget = stFetchAddr;
		endcase
	end

endmodule

// File: logic/cpuControlPkg.sv
package cpuControlPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// field and control word types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] irT;
	typedef logic [3:0]  flagsT;
	typedef logic [3:0]  condT;
	typedef logic [2:0]  opClassT;
	typedef logic [4:0]  aluOpT;
	typedef logic [2:0]  shiftT;
	typedef logic [5:0]  shiftSelT;
	typedef logic [1:0]  sel2T;
	typedef logic [2:0]  sel3T;

	// one state per micro step with no load/store states
	typedef enum logic [3:0] {
		stIdle,
		stFetchAddr,
		stFetchInc,
		stFetchWait,
		stDecode,
		stDpShift,
		stDpFlags,
		stDpImm,
		stBrTarget,
		stBrWrite,
		stBrLink
	} stateT;

	// instruction classes in ir[27:25]
	localparam opClassT OPC_DP_SHIFT = 3'b000;
	localparam opClassT OPC_DP_IMM   = 3'b001;
	localparam opClassT OPC_BRANCH   = 3'b101;

	localparam int IR_CLASS_LSB = 25;
	localparam int IR_COND_LSB  = 28;
	localparam int IR_LINK_BIT  = 20;

	// ALU operations driven by the control word
	localparam aluOpT ALU_PASS    = 5'b10000;
	localparam aluOpT ALU_INC     = 5'b10001;
	localparam aluOpT ALU_FROM_IR = 5'b10011;
	localparam aluOpT ALU_ADD     = 5'b00100;

	// condition field encodings
	localparam condT COND_EQ = 4'b0000;
	localparam condT COND_NE = 4'b0001;
	localparam condT COND_CS = 4'b0010;
	localparam condT COND_CC = 4'b0011;
	localparam condT COND_MI = 4'b0100;
	localparam condT COND_PL = 4'b0101;
	localparam condT COND_VS = 4'b0110;
	localparam condT COND_VC = 4'b0111;
	localparam condT COND_HI = 4'b1000;
	localparam condT COND_LS = 4'b1001;
	localparam condT COND_GE = 4'b1010;
	localparam condT COND_LT = 4'b1011;
	localparam condT COND_GT = 4'b1100;
	localparam condT COND_LE = 4'b1101;
	localparam condT COND_AL = 4'b1110;
	localparam condT COND_NV = 4'b1111;

endpackage
